//--- Makefile
VERILATOR ?= verilator
TOP       ?= sw_core_tb
FILELIST  ?= sw_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# a $fatal in the run gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/sw_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sw_core_assertions (
    input wire                  clk,
    input wire                  rst,
    input wire                  o_ready,
    input wire                  o_valid,
    input wire sw_pkg::score_t  o_score
);

    // number of assertion failures so far
    int fail_count = 0;

    // result strobe is a single-cycle pulse
    valid_one_cycle: assert property (@(posedge clk) disable iff (rst) o_valid |=> !o_valid)
        else begin
            $error("o_valid stayed high for more than one cycle");
            fail_count = fail_count + 1;
        end

    // a new pair is never taken in the result cycle
    ready_valid_excl: assert property (@(posedge clk) disable iff (rst) !(o_ready && o_valid))
        else begin
            $error("o_ready and o_valid were high together");
            fail_count = fail_count + 1;
        end

    // score was settled before the strobe
    score_stable: assert property (@(posedge clk) disable iff (rst) o_valid |-> $stable(o_score))
        else begin
            $error("o_score changed in the o_valid cycle");
            fail_count = fail_count + 1;
        end

    ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> o_ready)
        else begin
            $error("o_ready was low when reset was released");
            fail_count = fail_count + 1;
        end

endmodule

bind sw_core sw_core_assertions u_assertions (
    .clk     (clk),
    .rst     (rst),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_score (o_score)
);

`default_nettype wire

//--- bench/sw_core_stim.txt
# ref_len read_len ref_hex read_hex exp_score exp_row exp_col ready_hold
# bases A=0 C=1 G=2 T=3, base 0 in the top bits, ready_hold -1 means random
16 16 1B4B1E39 1B4B1E39 16 15 15 0
16 16 1B4B1E39 1B4B9E39 11 15 15 2
16 15 1B4B1E39 1B4B78E4 9 14 15 -1
15 16 1B4B1E38 1B4B478E 9 15 14 0
16 16 00000000 55555555 0 0 0 4
7 9 AAA80000 FFFFC000 0 0 0 -1
5 5 8D800000 8D800000 5 4 4 6
12 4 1B4B1E00 4B000000 4 3 7 0
3 8 8C000000 58F10000 3 4 2 -1
5 2 18400000 10000000 2 1 1 1
1 1 C0000000 C0000000 1 0 0 3
16 16 1B4B1E39 1B4B1E39 16 15 15 -1

//--- bench/sw_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_defines.svh"

module sw_core_tb;

    localparam int HALF_PERIOD = 4;
    localparam int RAND_HOLD = 8;
    localparam int WAIT_LIMIT = 4 * `SW_MAX_LEN;
    localparam int MOST_NEG = -(1 << (`SW_SCORE_W - 1));

    logic           clk;
    logic           rst;
    logic           i_valid;
    sw_pkg::seq_t   i_seq_ref;
    sw_pkg::seq_t   i_seq_read;
    sw_pkg::len_t   i_ref_len;
    sw_pkg::len_t   i_read_len;
    logic           i_ready;
    wire            o_ready;
    wire            o_valid;
    sw_pkg::score_t o_score;
    sw_pkg::pos_t   o_row;
    sw_pkg::pos_t   o_column;

    // one entry per case line
    int           ref_len_q [$];
    int           read_len_q [$];
    sw_pkg::seq_t ref_q [$];
    sw_pkg::seq_t read_q [$];
    int           score_q [$];
    int           row_q [$];
    int           col_q [$];
    int           hold_q [$];

    int     seed;
    int     max_hold;
    longint watchdog_ns;
    logic   watchdog_armed;

    sw_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_seq_ref  (i_seq_ref),
        .i_seq_read (i_seq_read),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .i_ready    (i_ready),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_column   (o_column)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            stop_run($sformatf("Mismatch at time %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic read_cases();
        int           fd;
        int           n;
        string        line;
        int           rl;
        int           dl;
        int           sc;
        int           rw;
        int           cl;
        int           hd;
        sw_pkg::seq_t rs;
        sw_pkg::seq_t ds;
        fd = $fopen("bench/sw_core_stim.txt", "r");
        assert (fd != 0) else stop_run("could not open the stimulus file");
        while ($fgets(line, fd) > 0) begin
            // skip comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %h %h %d %d %d %d", rl, dl, rs, ds, sc, rw, cl, hd);
                assert (n == 8) else stop_run("a stimulus line does not have eight fields");
                if (hd < 0) begin
                    hd = int'($unsigned($random(seed)) % RAND_HOLD);
                end
                ref_len_q.push_back(rl);
                read_len_q.push_back(dl);
                ref_q.push_back(rs);
                read_q.push_back(ds);
                score_q.push_back(sc);
                row_q.push_back(rw);
                col_q.push_back(cl);
                hold_q.push_back(hd);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int idx);
        int a;
        int b;
        int hold;
        int done_at;
        int cyc;
        a = ref_len_q[idx];
        b = read_len_q[idx];
        hold = hold_q[idx];
        cyc = 0;
        while (!o_ready && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        assert (o_ready) else stop_run("the core never raised o_ready");
        i_valid    = 1'b1;
        i_seq_ref  = ref_q[idx];
        i_seq_read = read_q[idx];
        i_ref_len  = sw_pkg::len_t'(a);
        i_read_len = sw_pkg::len_t'(b);
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        check_value("o_ready after accept", int'(o_ready), 0);
        // load, A + B - 1 calc steps, then B select steps
        done_at = a + 2 * b;
        for (int k = 1; k <= done_at + hold; k++) begin
            @(posedge clk);
            #1;
            check_value("o_valid with i_ready low", int'(o_valid), 0);
            if (k >= done_at) begin
                check_value("o_score while held", int'(o_score), score_q[idx]);
            end
        end
        i_ready = 1'b1;
        cyc = 0;
        while (!o_valid && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        assert (o_valid) else stop_run("o_valid never rose after i_ready went high");
        i_ready = 1'b0;
        check_value("cycles from i_ready to o_valid", cyc, 1);
        check_value("o_score", int'(o_score), score_q[idx]);
        check_value("o_row", int'(o_row), row_q[idx]);
        check_value("o_column", int'(o_column), col_q[idx]);
        check_value("o_ready with o_valid", int'(o_ready), 0);
        @(posedge clk);
        #1;
        check_value("o_valid after strobe", int'(o_valid), 0);
        check_value("o_ready after result", int'(o_ready), 1);
    endtask

    // ends a run that stops making progress
    initial begin
        wait (watchdog_armed);
        #(watchdog_ns);
        $display("watchdog expired before all cases finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped by watchdog");
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        i_valid        = 1'b0;
        i_seq_ref      = '0;
        i_seq_read     = '0;
        i_ref_len      = '0;
        i_read_len     = '0;
        i_ready        = 1'b0;
        seed           = 32'h1adc_5700;
        max_hold       = 0;
        watchdog_armed = 1'b0;
        read_cases();
        foreach (hold_q[i]) begin
            if (hold_q[i] > max_hold) begin
                max_hold = hold_q[i];
            end
        end
        watchdog_ns = longint'(hold_q.size()) * (4 * `SW_MAX_LEN + max_hold + 10) * 8;
        watchdog_armed = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("o_ready after reset", int'(o_ready), 1);
        check_value("o_valid after reset", int'(o_valid), 0);
        check_value("o_row after reset", int'(o_row), 0);
        check_value("o_column after reset", int'(o_column), 0);
        check_value("o_score after reset", int'(o_score), MOST_NEG);
        for (int i = 0; i < ref_len_q.size(); i++) begin
            run_case(i);
        end
        if (dut_i.u_assertions.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "bound assertions reported failures");
        end
    end

endmodule

`default_nettype wire

//--- rtl/sw_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_defines.svh"

module sw_array (
    input  wire         clk,
    input  wire         rst,
    sw_array_if.array   arr
);

    localparam int N = `SW_MAX_LEN;

    // per-cell outputs of this cycle
    sw_pkg::score_t score_c  [N];
    sw_pkg::score_t insert_c [N];
    sw_pkg::score_t delete_c [N];

    // one-cycle copies, the left and top inputs
    sw_pkg::score_t align_d  [N];
    sw_pkg::score_t insert_d [N];
    sw_pkg::score_t delete_d [N];
    // two-cycle copy, the diagonal input
    sw_pkg::score_t align_dd [N];

    // reference base chain, entry i feeds cell i
    logic          fwd_valid [N+1];
    sw_pkg::base_t fwd_base  [N+1];

    assign fwd_valid[0] = arr.a_valid;
    assign fwd_base[0]  = arr.a_base;

    for (genvar i = 0; i < N; i++) begin : g_cell
        sw_pkg::score_t top_align;
        sw_pkg::score_t top_insert;
        sw_pkg::score_t diag_align;

        if (i == 0) begin : g_first
            assign top_align  = '0;
            assign top_insert = '0;
            assign diag_align = '0;
        end else begin : g_next
            assign top_align  = align_d[i-1];
            assign top_insert = insert_d[i-1];
            assign diag_align = align_dd[i-1];
        end

        // clear also flushes any base still in the chain
        sw_cell u_cell (
            .clk           (clk),
            .rst           (rst),
            .i_a_valid     (fwd_valid[i] && !arr.clear),
            .i_a_base      (fwd_base[i]),
            .i_b_valid     (arr.b_valid),
            .i_b_base      (arr.b_bases[2*N-1-2*i -: 2]),
            .i_diag_align  (diag_align),
            .i_top_align   (top_align),
            .i_top_insert  (top_insert),
            .i_left_align  (align_d[i]),
            .i_left_insert (insert_d[i]),
            .i_left_delete (delete_d[i]),
            .o_align       (),
            .o_insert      (insert_c[i]),
            .o_delete      (delete_c[i]),
            .o_score       (score_c[i]),
            .o_a_valid     (fwd_valid[i+1]),
            .o_a_base      (fwd_base[i+1])
        );

        assign arr.cell_score[i] = score_c[i];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N; i++) begin
                align_d[i]  <= '0;
                insert_d[i] <= '0;
                delete_d[i] <= '0;
                align_dd[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                align_d[i]  <= arr.clear ? '0 : score_c[i];
                insert_d[i] <= arr.clear ? '0 : insert_c[i];
                delete_d[i] <= arr.clear ? '0 : delete_c[i];
                align_dd[i] <= arr.clear ? '0 : align_d[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sw_array_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_defines.svh"

interface sw_array_if;

    // reference base entering cell 0
    logic          a_valid;
    sw_pkg::base_t a_base;

    // read bases, cell i takes base i
    logic          b_valid;
    sw_pkg::seq_t  b_bases;

    // zeroes stored scores and row maxima
    logic          clear;

    // best score of every cell in the current cycle
    sw_pkg::score_t cell_score [`SW_MAX_LEN];

    modport ctrl (output a_valid, a_base, b_valid, b_bases, clear);
    modport array (input a_valid, a_base, b_valid, b_bases, clear, output cell_score);
    modport tracker (input cell_score, clear);

endinterface

`default_nettype wire

//--- rtl/sw_cell.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_defines.svh"

module sw_cell (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_a_valid,
    input  wire sw_pkg::base_t   i_a_base,
    input  wire                  i_b_valid,
    input  wire sw_pkg::base_t   i_b_base,
    input  wire sw_pkg::score_t  i_diag_align,
    input  wire sw_pkg::score_t  i_top_align,
    input  wire sw_pkg::score_t  i_top_insert,
    input  wire sw_pkg::score_t  i_left_align,
    input  wire sw_pkg::score_t  i_left_insert,
    input  wire sw_pkg::score_t  i_left_delete,
    output sw_pkg::score_t       o_align,
    output sw_pkg::score_t       o_insert,
    output sw_pkg::score_t       o_delete,
    output sw_pkg::score_t       o_score,
    output logic                 o_a_valid,
    output sw_pkg::base_t        o_a_base
);

    sw_pkg::score_t ins_open;
    sw_pkg::score_t ins_ext;
    sw_pkg::score_t del_open;
    sw_pkg::score_t del_ext;

    function automatic sw_pkg::score_t max2(input sw_pkg::score_t a, input sw_pkg::score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        ins_open = i_top_align + sw_pkg::score_t'(`SW_GAP_OPEN);
        ins_ext  = i_top_insert + sw_pkg::score_t'(`SW_GAP_EXTEND);
        del_open = i_left_align + sw_pkg::score_t'(`SW_GAP_OPEN);
        del_ext  = i_left_delete + sw_pkg::score_t'(`SW_GAP_EXTEND);

        if (i_a_valid && i_b_valid) begin
            o_align = i_diag_align + ((i_a_base == i_b_base) ?
                                      sw_pkg::score_t'(`SW_MATCH) :
                                      sw_pkg::score_t'(`SW_MISMATCH));
            // gap scores never drop below zero
            o_insert = max2(max2(ins_open, ins_ext), '0);
            o_delete = max2(max2(del_open, del_ext), '0);
            o_score  = max2(max2(o_align, o_insert), max2(o_delete, '0));
        end else begin
            // idle cell keeps its row values unchanged
            o_align  = i_left_align;
            o_insert = i_left_insert;
            o_delete = i_left_delete;
            o_score  = i_left_align;
        end
    end

    // reference base moves one cell per clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_a_valid <= 1'b0;
        end else begin
            o_a_valid <= i_a_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_a_base <= i_a_base;
    end

endmodule

`default_nettype wire

//--- rtl/sw_core.sv
`timescale 1ns/1ps
`default_nettype none

module sw_core (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_valid,
    input  wire sw_pkg::seq_t    i_seq_ref,
    input  wire sw_pkg::seq_t    i_seq_read,
    input  wire sw_pkg::len_t    i_ref_len,
    input  wire sw_pkg::len_t    i_read_len,
    input  wire                  i_ready,
    output wire                  o_ready,
    output wire                  o_valid,
    output wire sw_pkg::score_t  o_score,
    output wire sw_pkg::pos_t    o_row,
    output wire sw_pkg::pos_t    o_column
);

    logic          calc;
    sw_pkg::step_t step;
    logic          sel_en;
    sw_pkg::pos_t  sel_row;
    sw_pkg::pos_t  best_row;
    sw_pkg::pos_t  best_col;

    sw_array_if arr_if ();

    sw_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_seq_ref  (i_seq_ref),
        .i_seq_read (i_seq_read),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .i_ready    (i_ready),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_row      (o_row),
        .o_column   (o_column),
        .i_best_row (best_row),
        .i_best_col (best_col),
        .o_calc     (calc),
        .o_step     (step),
        .o_sel_en   (sel_en),
        .o_sel_row  (sel_row),
        .arr        (arr_if.ctrl)
    );

    sw_array u_array (
        .clk (clk),
        .rst (rst),
        .arr (arr_if.array)
    );

    // o_score follows the selected best directly
    sw_max_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .i_calc       (calc),
        .i_step       (step),
        .i_sel_en     (sel_en),
        .i_sel_row    (sel_row),
        .arr          (arr_if.tracker),
        .o_best_score (o_score),
        .o_best_row   (best_row),
        .o_best_col   (best_col)
    );

endmodule

`default_nettype wire

//--- rtl/sw_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_defines.svh"

module sw_ctrl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_valid,
    input  wire sw_pkg::seq_t   i_seq_ref,
    input  wire sw_pkg::seq_t   i_seq_read,
    input  wire sw_pkg::len_t   i_ref_len,
    input  wire sw_pkg::len_t   i_read_len,
    input  wire                 i_ready,
    output logic                o_ready,
    output logic                o_valid,
    output sw_pkg::pos_t        o_row,
    output sw_pkg::pos_t        o_column,
    input  wire sw_pkg::pos_t   i_best_row,
    input  wire sw_pkg::pos_t   i_best_col,
    output logic                o_calc,
    output sw_pkg::step_t       o_step,
    output logic                o_sel_en,
    output sw_pkg::pos_t        o_sel_row,
    sw_array_if.ctrl            arr
);

    sw_pkg::ctrl_state_e state;
    sw_pkg::ctrl_state_e state_n;
    sw_pkg::step_t       step;
    sw_pkg::seq_t        ref_shift;
    sw_pkg::seq_t        read_seq;
    sw_pkg::len_t        ref_len;
    sw_pkg::len_t        read_len;
    logic                calc_last;
    logic                sel_last;
    logic                release_res;
    logic                accept;

    // wavefront needs A + B - 1 steps, selection B rows
    assign calc_last = (step == sw_pkg::step_t'(ref_len) + sw_pkg::step_t'(read_len)
                                - sw_pkg::step_t'(1));
    assign sel_last    = (step == sw_pkg::step_t'(read_len) - sw_pkg::step_t'(1));
    assign release_res = (state == sw_pkg::S_DONE) && i_ready;
    assign accept      = o_ready && i_valid;

    always_comb begin
        state_n = state;
        case (state)
            sw_pkg::S_IDLE:   state_n = accept ? sw_pkg::S_LOAD : state;
            sw_pkg::S_LOAD:   state_n = sw_pkg::S_CALC;
            sw_pkg::S_CALC:   state_n = calc_last ? sw_pkg::S_SELECT : state;
            sw_pkg::S_SELECT: state_n = sel_last ? sw_pkg::S_DONE : state;
            sw_pkg::S_DONE:   state_n = i_ready ? sw_pkg::S_IDLE : state;
            default:          state_n = sw_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sw_pkg::S_IDLE;
            step  <= '0;
        end else begin
            state <= state_n;
            case (state)
                sw_pkg::S_LOAD:   step <= sw_pkg::step_t'(1);
                sw_pkg::S_CALC:   step <= calc_last ? '0 : step + 1'b1;
                sw_pkg::S_SELECT: step <= sel_last ? '0 : step + 1'b1;
                default:          step <= '0;
            endcase
        end
    end

    // capture on accept, then feed one reference base per step
    always_ff @(posedge clk) begin
        if (accept) begin
            ref_shift <= i_seq_ref;
            read_seq  <= i_seq_read;
            ref_len   <= i_ref_len;
            read_len  <= i_read_len;
        end else if (o_calc) begin
            ref_shift <= {ref_shift[2*`SW_MAX_LEN-3:0], 2'b00};
        end
    end

    // result strobe, position only valid with it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid  <= 1'b0;
            o_row    <= '0;
            o_column <= '0;
        end else begin
            o_valid  <= release_res;
            o_row    <= release_res ? i_best_row : '0;
            o_column <= release_res ? i_best_col : '0;
        end
    end

    // no new pair taken while the result strobe is out
    assign o_ready   = (state == sw_pkg::S_IDLE) && !o_valid;
    assign o_calc    = (state == sw_pkg::S_CALC);
    assign o_sel_en  = (state == sw_pkg::S_SELECT);
    assign o_step    = step;
    assign o_sel_row = sw_pkg::pos_t'(step);

    assign arr.clear   = (state == sw_pkg::S_IDLE);
    assign arr.a_valid = o_calc && (step <= sw_pkg::step_t'(ref_len));
    assign arr.a_base  = ref_shift[2*`SW_MAX_LEN-1 -: 2];
    assign arr.b_valid = o_calc;
    assign arr.b_bases = read_seq;

endmodule

`default_nettype wire

//--- rtl/sw_defines.svh
`ifndef SW_DEFINES_SVH
`define SW_DEFINES_SVH

// longest reference or read, one array cell per read base
`define SW_MAX_LEN 16

// signed score width
`define SW_SCORE_W 10

// per-base scores
`define SW_MATCH 1
`define SW_MISMATCH (-4)

// affine gap, open once then extend
`define SW_GAP_OPEN (-6)
`define SW_GAP_EXTEND (-1)

`endif

//--- rtl/sw_max_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_defines.svh"

module sw_max_tracker (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_calc,
    input  wire sw_pkg::step_t  i_step,
    input  wire                 i_sel_en,
    input  wire sw_pkg::pos_t   i_sel_row,
    sw_array_if.tracker         arr,
    output sw_pkg::score_t      o_best_score,
    output sw_pkg::pos_t        o_best_row,
    output sw_pkg::pos_t        o_best_col
);

    localparam int N = `SW_MAX_LEN;
    localparam sw_pkg::score_t MOST_NEG = {1'b1, {(`SW_SCORE_W-1){1'b0}}};

    sw_pkg::score_t row_max [N];
    sw_pkg::pos_t   row_col [N];

    // running maximum of each row and where it first occurs
    always_ff @(posedge clk) begin
        if (arr.clear) begin
            for (int i = 0; i < N; i++) begin
                row_max[i] <= '0;
                row_col[i] <= '0;
            end
        end else if (i_calc) begin
            for (int i = 0; i < N; i++) begin
                if (arr.cell_score[i] > row_max[i]) begin
                    row_max[i] <= arr.cell_score[i];
                    // cell i is on column step - i - 1
                    row_col[i] <= sw_pkg::pos_t'(i_step - sw_pkg::step_t'(i) - 1'b1);
                end
            end
        end
    end

    // serial scan, strict compare keeps the lowest row on ties
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_best_score <= MOST_NEG;
            o_best_row   <= '0;
            o_best_col   <= '0;
        end else if (arr.clear) begin
            o_best_score <= MOST_NEG;
            o_best_row   <= '0;
            o_best_col   <= '0;
        end else if (i_sel_en && (row_max[i_sel_row] > o_best_score)) begin
            o_best_score <= row_max[i_sel_row];
            o_best_row   <= i_sel_row;
            o_best_col   <= row_col[i_sel_row];
        end
    end

endmodule

`default_nettype wire

//--- rtl/sw_pkg.sv
`default_nettype none

`include "sw_defines.svh"

package sw_pkg;

    // 2-bit nucleotide code
    typedef logic [1:0] base_t;
    typedef logic signed [`SW_SCORE_W-1:0] score_t;
    typedef logic [$clog2(`SW_MAX_LEN)-1:0] pos_t;
    // 1-based length, one bit wider than a position
    typedef logic [$clog2(`SW_MAX_LEN):0] len_t;
    // wavefront step, up to twice the max length
    typedef logic [$clog2(2*`SW_MAX_LEN):0] step_t;
    // base 0 in the top two bits
    typedef logic [2*`SW_MAX_LEN-1:0] seq_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_CALC,
        S_SELECT,
        S_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- sw_core.f
+incdir+rtl
rtl/sw_pkg.sv
rtl/sw_array_if.sv
rtl/sw_cell.sv
rtl/sw_array.sv
rtl/sw_max_tracker.sv
rtl/sw_ctrl.sv
rtl/sw_core.sv
bench/sw_core_assertions.sv
bench/sw_core_tb.sv
